/* files.f */
+incdir+verilog
verilog/scan_pkg.sv
verilog/dfa_if.sv
verilog/regex_dfa.sv
verilog/stream_matcher.sv
verilog/wb_scan_regs.sv
verilog/regex_scan_top.sv
tb/tb_regex_scan.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the regex scanner testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_regex_scan -f files.f > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_regex_scan > sim.log 2>&1
grep -q "Errors found" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; } \
  || grep -q "No errors" sim.log \
  || { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"

/* tb/scan_trace.txt */
# Columns: command, then its arguments; adr 0 is the count, adr 1 the enable mask
# T name | L id new | S text | R n | E | W adr hex | X adr hex | F fired | P
T single_match
L 3 1
S xxabbbcyy
F 1
E
X 0 0001
P
T count_once
L 3 0
S abcxabbc
R 2
F 1
E
X 0 0002
L 4 1
R 12
F 0
E
X 0 0002
P
T disabled_stream
W 1 fff7
X 1 fff7
L 3 1
S abcq
F 1
E
F 0
X 0 0002
W 1 ffff
X 1 ffff
P
T span_packets
L 5 1
S xab
E
L 7 1
S ababz
E
L 5 0
S bc
R 2
F 1
E
X 0 0003
P
T new_stream_reset
L 6 1
S ab
E
L 6 1
S c
R 2
F 0
E
X 0 0003
P
T clear_count
W 0 0000
X 0 0000
L 8 1
S aabcc
R 1
F 1
E
X 0 0001
P

/* tb/tb_regex_scan.sv */
`timescale 1ns/10ps
`include "scan_config.svh"

module tb_regex_scan;
  import scan_pkg::*;

  // Idle gaps that respect the caller rules of the byte port
  localparam int GAP_AFTER_LOAD   = 4;
  localparam int GAP_AFTER_BYTES  = 6;
  localparam int GAP_AFTER_EOP    = 3;
  localparam int GAP_BEFORE_FIRED = 6;
  localparam int WB_MAX_WAIT      = 8;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      load_state;
  logic                      new_stream_id;
  logic [`SCAN_STREAM_W-1:0] stream_id;
  logic [7:0]                char_in;
  logic                      char_in_vld;
  logic                      eop;
  logic                      fired;
  logic                      cyc;
  logic                      stb;
  logic                      we;
  logic                      adr;
  logic [15:0]               dat_w;
  logic [15:0]               dat_r;
  logic                      ack;

  // Scoreboard
  int    error_count = 0;
  int    test_errors = 0;
  int    test_count = 0;
  int    failed_tests = 0;
  int    checks_run = 0;
  string cur_test = "none";

  // Run limit, set once the trace length is known
  int cycle_count = 0;
  int cycle_limit = 200;

  logic [31:0] rng_state = 32'd35909;
  logic [7:0]  byte_q[$];

  regex_scan_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .eop           (eop),
    .fired         (fired),
    .cyc           (cyc),
    .stb           (stb),
    .we            (we),
    .adr           (adr),
    .dat_w         (dat_w),
    .dat_r         (dat_r),
    .ack           (ack)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the trace did not finish", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  // Next value of the filler generator
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // One clock, then inputs change 1 ns later
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic load_stream(input int id, input int is_new);
    load_state    = 1'b1;
    stream_id     = stream_id_t'(id);
    new_stream_id = (is_new != 0);
    step();
    load_state = 1'b0;
    idle(GAP_AFTER_LOAD);
  endtask

  // Bytes go out back to back, one per cycle
  task automatic send_queue();
    foreach (byte_q[i])
    begin
      char_in     = byte_q[i];
      char_in_vld = 1'b1;
      step();
    end
    char_in_vld = 1'b0;
    byte_q.delete();
    idle(GAP_AFTER_BYTES);
  endtask

  task automatic end_packet();
    eop = 1'b1;
    step();
    eop = 1'b0;
    idle(GAP_AFTER_EOP);
  endtask

  // Classic cycle, request held through the edge that samples ack
  task automatic wb_access(input logic write, input logic addr, input logic [15:0] data,
                           output logic [15:0] rdata, output logic got_ack);
    int waited;
    cyc     = 1'b1;
    stb     = 1'b1;
    we      = write;
    adr     = addr;
    dat_w   = data;
    got_ack = 1'b0;
    rdata   = '0;
    waited  = 0;
    while (!got_ack && waited < WB_MAX_WAIT)
    begin
      step();
      waited++;
      if (ack)
      begin
        got_ack = 1'b1;
        rdata   = dat_r;
      end
    end
    step();
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic note_missing_ack(input string kind);
    $display("%s: the Wishbone %s got no ack", cur_test, kind);
    error_count++;
    test_errors++;
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    checks_run++;
    if (act !== exp)
    begin
      $display("CHECK FAILED %s count: expected %h, actual %h", name, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_mask(input string name, input logic [15:0] exp,
                            input logic [15:0] act);
    checks_run++;
    if (act !== exp)
    begin
      $display("CHECK FAILED %s mask: expected %h, actual %h", name, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_fired(input string name, input logic exp, input logic act);
    checks_run++;
    if (act !== exp)
    begin
      $display("CHECK FAILED %s fired: expected %b, actual %b", name, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  initial
  begin
    int               fd;
    int               code;
    int               line_count;
    int               arg_a;
    int               arg_b;
    logic [8*256-1:0] line_buf;
    logic [8*16-1:0]  cmd;
    logic [8*64-1:0]  text_raw;
    logic [15:0]      rdata;
    logic             got_ack;
    logic             done;
    load_state    = 1'b0;
    new_stream_id = 1'b0;
    stream_id     = '0;
    char_in       = '0;
    char_in_vld   = 1'b0;
    eop           = 1'b0;
    cyc           = 1'b0;
    stb           = 1'b0;
    we            = 1'b0;
    adr           = 1'b0;
    dat_w         = '0;
    rst_n         = 1'b0;
    // Size the run limit from the trace length
    line_count = 0;
    fd = $fopen("tb/scan_trace.txt", "r");
    if (fd != 0)
    begin
      while ($fgets(line_buf, fd) != 0)
        line_count++;
      $fclose(fd);
    end
    cycle_limit = 40 * line_count + 200;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle(2);
    fd = $fopen("tb/scan_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the trace file tb/scan_trace.txt");
      error_count++;
    end
    else
    begin
      done = 1'b0;
      while (!done)
      begin
        cmd = '0;
        text_raw = '0;
        code = $fscanf(fd, "%s", cmd);
        if (code != 1)
          done = 1'b1;
        else
        begin
          case (cmd[7:0])
            "#": code = $fgets(line_buf, fd);
            "T":
            begin
              code = $fscanf(fd, "%s", text_raw);
              cur_test = string'(text_raw);
              test_errors = 0;
              test_count++;
            end
            "L":
            begin
              code = $fscanf(fd, "%d %d", arg_a, arg_b);
              load_stream(arg_a, arg_b);
            end
            "S":
            begin
              code = $fscanf(fd, "%s", text_raw);
              // Text sits right aligned, zero bytes are padding
              for (int i = 63; i >= 0; i--)
                if (text_raw[i*8 +: 8] != 8'h00)
                  byte_q.push_back(text_raw[i*8 +: 8]);
              send_queue();
            end
            "R":
            begin
              code = $fscanf(fd, "%d", arg_a);
              // Filler from d to z never starts or extends a match
              repeat (arg_a)
              begin
                rng_state = xorshift32(rng_state);
                byte_q.push_back(8'h64 + 8'(rng_state % 32'd23));
              end
              send_queue();
            end
            "E": end_packet();
            "W":
            begin
              code = $fscanf(fd, "%d %h", arg_a, arg_b);
              wb_access(1'b1, arg_a[0], 16'(arg_b), rdata, got_ack);
              if (!got_ack)
                note_missing_ack("write");
            end
            "X":
            begin
              code = $fscanf(fd, "%d %h", arg_a, arg_b);
              wb_access(1'b0, arg_a[0], 16'h0000, rdata, got_ack);
              if (!got_ack)
                note_missing_ack("read");
              else if (reg_addr_t'(arg_a[0]) == REG_COUNT)
                check_count(cur_test, count_t'(arg_b), count_t'(rdata));
              else
                check_mask(cur_test, 16'(arg_b), rdata);
            end
            "F":
            begin
              code = $fscanf(fd, "%d", arg_a);
              idle(GAP_BEFORE_FIRED);
              check_fired(cur_test, arg_a[0], fired);
            end
            "P":
            begin
              if (test_errors == 0)
                $display("Test %s passed", cur_test);
              else
              begin
                $display("Test %s failed with %0d mismatches", cur_test, test_errors);
                failed_tests++;
              end
            end
            default:
            begin
              $display("Unknown trace command %s", cmd);
              error_count++;
            end
          endcase
        end
      end
      $fclose(fd);
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors", test_count, failed_tests,
             checks_run, error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* verilog/regex_scan_top.sv */
`timescale 1ns/10ps
`include "scan_config.svh"

module regex_scan_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // Byte port
  input  logic                      load_state,
  input  logic                      new_stream_id,
  input  logic [`SCAN_STREAM_W-1:0] stream_id,
  input  logic [7:0]                char_in,
  input  logic                      char_in_vld,
  input  logic                      eop,
  output logic                      fired,
  // Wishbone slave
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic                      adr,
  input  logic [15:0]               dat_w,
  output logic [15:0]               dat_r,
  output logic                      ack
);
  import scan_pkg::*;

  reg_addr_t                    wb_adr;
  count_t                       count;
  logic [`SCAN_NUM_STREAMS-1:0] enable_mask;
  logic                         count_clr;

  // Bus address bit as register select
  assign wb_adr = reg_addr_t'(adr);

  dfa_if u_dfa_if ();

  stream_matcher u_matcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .eop           (eop),
    .enable_mask   (enable_mask),
    .count_clr     (count_clr),
    .count         (count),
    .fired         (fired),
    .dfa           (u_dfa_if.ctx)
  );

  regex_dfa u_dfa (
    .clk   (clk),
    .rst_n (rst_n),
    .dfa   (u_dfa_if.dfa)
  );

  wb_scan_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cyc         (cyc),
    .stb         (stb),
    .we          (we),
    .adr         (wb_adr),
    .dat_w       (dat_w),
    .count       (count),
    .dat_r       (dat_r),
    .ack         (ack),
    .enable_mask (enable_mask),
    .count_clr   (count_clr)
  );

endmodule

/* verilog/wb_scan_regs.sv */
`timescale 1ns/10ps
`include "scan_config.svh"

module wb_scan_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  scan_pkg::reg_addr_t          adr,
  input  logic [15:0]                  dat_w,
  input  scan_pkg::count_t             count,
  output logic [15:0]                  dat_r,
  output logic                         ack,
  output logic [`SCAN_NUM_STREAMS-1:0] enable_mask,
  output logic                         count_clr
);
  import scan_pkg::*;

  // New request, not yet acknowledged
  logic req;
  logic wr_req;

  assign req    = cyc && stb && !ack;
  assign wr_req = req && we;

  // Ack, mask and clear pulse
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ack         <= 1'b0;
      enable_mask <= '1;
      count_clr   <= 1'b0;
    end
    else
    begin
      // Single cycle ack, one clock after the request
      ack       <= req;
      count_clr <= wr_req && (adr == REG_COUNT);
      if (wr_req && (adr == REG_ENABLE))
        enable_mask <= dat_w[`SCAN_NUM_STREAMS-1:0];
    end
  end

  // Read data lines up with ack
  always_ff @(posedge clk)
  begin
    if (req)
    begin
      case (adr)
        REG_COUNT:  dat_r <= 16'(count);
        REG_ENABLE: dat_r <= 16'(enable_mask);
        default:    dat_r <= '0;
      endcase
    end
  end

  // Master holds the request until ack
  property p_ack_in_cycle;
    @(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb);
  endproperty
  a_ack_in_cycle: assert property (p_ack_in_cycle)
    else $error("Wishbone ack outside of an active request");

endmodule

/* verilog/stream_matcher.sv */
`timescale 1ns/10ps
`include "scan_config.svh"

module stream_matcher (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         load_state,
  input  logic                         new_stream_id,
  input  scan_pkg::stream_id_t         stream_id,
  input  logic [7:0]                   char_in,
  input  logic                         char_in_vld,
  input  logic                         eop,
  input  logic [`SCAN_NUM_STREAMS-1:0] enable_mask,
  input  logic                         count_clr,
  output scan_pkg::count_t             count,
  output logic                         fired,
  dfa_if.ctx                           dfa
);
  import scan_pkg::*;

  // Saved DFA state, one word per stream
  dfa_state_t state_mem [`SCAN_NUM_STREAMS];

  // Stream of the packet in flight
  stream_id_t cur_id;
  logic       stream_enabled;

  // Restore stage, one cycle after load_state
  dfa_state_t restore_state;
  logic       restore_vld;

  // DFA outputs, registered
  dfa_state_t state_out_r;
  logic       accept_r;

  // Speculative match flag for the current packet
  logic match_flag;

  assign stream_enabled = enable_mask[cur_id];
  assign fired = match_flag;

  // Control side of the restore stage and the stream latch
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      restore_vld <= 1'b0;
      cur_id      <= '0;
    end
    else
    begin
      restore_vld <= load_state;
      if (load_state)
        cur_id <= stream_id;
    end
  end

  // New stream starts clean, known stream picks up where it stopped
  always_ff @(posedge clk)
  begin
    if (load_state)
      restore_state <= new_stream_id ? S_START : state_mem[stream_id];
  end

  // DFA valid inputs and accept register
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      dfa.char_vld     <= 1'b0;
      dfa.state_in_vld <= 1'b0;
      accept_r         <= 1'b0;
    end
    else
    begin
      dfa.char_vld     <= char_in_vld;
      dfa.state_in_vld <= restore_vld;
      accept_r         <= dfa.accept;
    end
  end

  // Payload side of the DFA registers
  always_ff @(posedge clk)
  begin
    dfa.char     <= char_in;
    dfa.state_in <= restore_state;
    state_out_r  <= dfa.state_out;
  end

  // Flag and counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      match_flag <= 1'b0;
      count      <= '0;
    end
    else
    begin
      // Fresh flag for every packet
      if (load_state)
        match_flag <= 1'b0;
      if (accept_r)
        match_flag <= 1'b1;
      // Disabled stream drops its result at eop
      if (eop && !stream_enabled)
        match_flag <= 1'b0;
      // Clear from the bus beats a same-cycle update
      if (count_clr)
        count <= '0;
      else if (eop && stream_enabled)
        count <= count + count_t'(match_flag);
    end
  end

  // Save state at eop so a match can span packets
  always_ff @(posedge clk)
  begin
    if (eop && stream_enabled)
      state_mem[cur_id] <= state_out_r;
  end

  property p_eop_not_with_char;
    @(posedge clk) disable iff (!rst_n) !(eop && char_in_vld);
  endproperty
  a_eop_not_with_char: assert property (p_eop_not_with_char)
    else $error("eop together with a valid byte");

  property p_load_not_with_char;
    @(posedge clk) disable iff (!rst_n) !(load_state && char_in_vld);
  endproperty
  a_load_not_with_char: assert property (p_load_not_with_char)
    else $error("load_state together with a valid byte");

endmodule

/* verilog/regex_dfa.sv */
`timescale 1ns/10ps

module regex_dfa (
  input logic clk,
  input logic rst_n,
  dfa_if.dfa  dfa
);
  import scan_pkg::*;

  // Pattern letters
  localparam logic [7:0] CH_A = 8'h61;
  localparam logic [7:0] CH_B = 8'h62;
  localparam logic [7:0] CH_C = 8'h63;

  dfa_state_t state;
  dfa_state_t next_state;

  // Transition for one byte
  // Any a restarts a candidate match, since the search is unanchored
  always_comb
  begin
    if (dfa.char == CH_A)
      next_state = S_SEEN_A;
    else
    begin
      case (state)
        S_SEEN_A:
          next_state = (dfa.char == CH_B) ? S_SEEN_AB : S_START;
        S_SEEN_AB:
        begin
          if (dfa.char == CH_B)
            next_state = S_SEEN_AB;
          else if (dfa.char == CH_C)
            next_state = S_ACCEPT;
          else
            next_state = S_START;
        end
        default:
          next_state = S_START;
      endcase
    end
  end

  // Restore has priority, the caller never overlaps it with a byte
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= S_START;
    else if (dfa.state_in_vld)
      state <= dfa.state_in;
    else if (dfa.char_vld)
      state <= next_state;
  end

  assign dfa.state_out = state;
  // Accept follows the state with no extra register
  assign dfa.accept = (state == S_ACCEPT);

  // Restore and byte come from separate pipeline stages of the matcher
  property p_no_restore_with_char;
    @(posedge clk) disable iff (!rst_n)
      !(dfa.state_in_vld && dfa.char_vld);
  endproperty
  a_no_restore_with_char: assert property (p_no_restore_with_char)
    else $error("DFA restore and byte in the same cycle");

endmodule

/* verilog/dfa_if.sv */
`timescale 1ns/10ps

// Bundle between the stream context block and the DFA
interface dfa_if;
  import scan_pkg::*;

  // Registered byte from the context block
  logic [7:0] char;
  logic       char_vld;

  // State restore at packet start
  dfa_state_t state_in;
  logic       state_in_vld;

  // Current DFA state and match indication
  dfa_state_t state_out;
  logic       accept;

  modport ctx (
    output char, char_vld, state_in, state_in_vld,
    input  state_out, accept
  );

  modport dfa (
    input  char, char_vld, state_in, state_in_vld,
    output state_out, accept
  );

endinterface

/* verilog/scan_pkg.sv */
package scan_pkg;

  `include "scan_config.svh"

  // DFA states for a, one or more b, then c
  // S_ACCEPT lasts one byte, the match flag holds the result
  typedef enum logic [1:0] {
    S_START   = 2'd0,
    S_SEEN_A  = 2'd1,
    S_SEEN_AB = 2'd2,
    S_ACCEPT  = 2'd3
  } dfa_state_t;

  // Register map of the Wishbone slave
  // Write to REG_COUNT clears the counter
  typedef enum logic {
    REG_COUNT  = 1'b0,
    REG_ENABLE = 1'b1
  } reg_addr_t;

  // Stream id as given with load_state
  typedef logic [`SCAN_STREAM_W-1:0] stream_id_t;

  // Count of enabled packets with at least one match
  typedef logic [`SCAN_COUNT_W-1:0] count_t;

endpackage

/* verilog/scan_config.svh */
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// Number of interleaved stream contexts
// Also the depth of the state memory and width of the enable mask
`define SCAN_NUM_STREAMS 16

// Stream id width, log2 of the stream count
`define SCAN_STREAM_W 4

// Width of the global packet match counter
`define SCAN_COUNT_W 16

`endif
